//--- sim/mem_checker.sv
module mem_checker #(
    parameter int n_rows = 1,
    parameter int n_rx = 1,
    parameter int mem_words = 64,
    parameter int fifo_depth = 4
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              wb_valid,
    input  mem_pkg::mem_wb_t  wb,
    input  logic              bk_wr_en,
    input  logic [31:0]       bk_addr,
    input  logic [31:0]       bk_wdata,
    input  logic              rx_push,
    input  logic              rx_full,
    input  logic              tx_pop,
    input  logic              tx_empty,
    input  logic [7:0]        tx_data,
    input  mem_pkg::mem_req_t tbl_req [n_rows],
    input  logic [95:0]       tbl_name [n_rows],
    input  logic [7:0]        rx_bytes [n_rx],
    input  logic [31:0]       bk_image [mem_words],
    input  logic              end_of_test,
    output int                value_errs,
    output int                other_errs,
    output logic              all_seen
);

    mem_pkg::mem_req_t row;
    mem_pkg::mem_wb_t exp_wb;
    logic [31:0] shadow [mem_words];
    logic is_uart;
    logic end_done;
    logic rx_take;
    int tx_rows [$];
    int rx_ptr;
    int rx_level;
    int wb_count;
    int tx_count;

    function automatic int word_index(input logic [31:0] addr);
        return (addr >> 2) % mem_words;
    endfunction

    // next writeback belongs to the oldest row not yet retired
    task automatic check_writeback();
        if (wb_count >= n_rows) begin
            $display("writeback for rd %0d arrived after the last request", wb.rd);
            other_errs++;
            return;
        end
        row = tbl_req[wb_count];
        is_uart = (row.addr[25:0] == mem_pkg::uart_addr);
        exp_wb.rd = row.rd;
        exp_wb.regwrite = 1'b0;
        exp_wb.data = '0;
        if (row.op == mem_pkg::op_alu) begin
            exp_wb.regwrite = 1'b1;
            exp_wb.data = row.addr;
        end else if (row.op == mem_pkg::op_load && is_uart) begin
            exp_wb.regwrite = 1'b1;
            exp_wb.data = {24'b0, rx_bytes[rx_ptr]};
            rx_ptr++;
            rx_level--;
        end else if (row.op == mem_pkg::op_load) begin
            exp_wb.regwrite = 1'b1;
            exp_wb.data = shadow[word_index(row.addr)];
        end
        if (wb.rd !== exp_wb.rd || wb.regwrite !== exp_wb.regwrite ||
                (exp_wb.regwrite && wb.data !== exp_wb.data)) begin
            $display("error: %0s expected %h actual %h", tbl_name[wb_count], exp_wb, wb);
            value_errs++;
        end
        // write-through store reaches backing memory in its completing cycle
        if (row.op == mem_pkg::op_store && !is_uart) begin
            shadow[word_index(row.addr)] = row.wdata;
            if ({bk_wr_en, bk_addr, bk_wdata} !== {1'b1, row.addr, row.wdata}) begin
                $display("error: %0s expected %h actual %h", tbl_name[wb_count],
                    {1'b1, row.addr, row.wdata}, {bk_wr_en, bk_addr, bk_wdata});
                value_errs++;
            end
        end
        wb_count++;
    endtask

    task automatic compare_tx_byte();
        if (tx_count >= tx_rows.size()) begin
            $display("transmit byte %h arrived with no serial store left to match", tx_data);
            other_errs++;
        end else begin
            row = tbl_req[tx_rows[tx_count]];
            if (tx_data !== row.wdata[7:0]) begin
                $display("error: %0s expected %h actual %h", tbl_name[tx_rows[tx_count]],
                    row.wdata[7:0], tx_data);
                value_errs++;
            end
        end
        tx_count++;
    endtask

    always @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < mem_words; i++) begin
                shadow[i] = bk_image[i];
            end
            tx_rows.delete();
            for (int i = 0; i < n_rows; i++) begin
                row = tbl_req[i];
                if (row.op == mem_pkg::op_store && row.addr[25:0] == mem_pkg::uart_addr) begin
                    tx_rows.push_back(i);
                end
            end
            rx_ptr = 0;
            rx_level = 0;
            wb_count = 0;
            tx_count = 0;
            value_errs = 0;
            other_errs = 0;
            all_seen = 1'b0;
            end_done = 1'b0;
        end else begin
            // receive fifo level follows accepted pushes and serial load pops
            rx_take = rx_push && (rx_level < fifo_depth);
            if (rx_full !== (rx_level == fifo_depth)) begin
                $display("error: rx_full expected %b actual %b", rx_level == fifo_depth,
                    rx_full);
                value_errs++;
            end
            if (wb_valid) begin
                check_writeback();
            end
            if (rx_take) begin
                rx_level++;
            end
            if (tx_pop && !tx_empty) begin
                compare_tx_byte();
            end
            all_seen = (wb_count >= n_rows) && (tx_count >= tx_rows.size());
            if (end_of_test && !end_done) begin
                end_done = 1'b1;
                if (wb_count < n_rows) begin
                    $display("only %0d of %0d writebacks arrived", wb_count, n_rows);
                    other_errs++;
                end
                if (tx_count < tx_rows.size()) begin
                    $display("only %0d of %0d transmit bytes were sent", tx_count,
                        tx_rows.size());
                    other_errs++;
                end
            end
        end
    end

endmodule

//--- sim/tb_mem_subsys.sv
module tb_mem_subsys;

    localparam int cache_lines = mem_pkg::cache_lines;
    localparam int refill_latency = mem_pkg::refill_latency;
    localparam int fifo_depth = mem_pkg::fifo_depth;
    localparam int n_rows = 19;
    localparam int n_rx = 2;
    localparam int mem_words = 64;
    localparam int rx_row = 10;
    localparam int tx_row = 12;
    localparam logic [31:0] uart = 32'hfffffffc;

    logic clk;
    logic rstn;
    logic req_valid;
    logic req_ready;
    mem_pkg::mem_req_t req;
    logic wb_valid;
    mem_pkg::mem_wb_t wb;
    logic bk_rd_en;
    logic bk_wr_en;
    logic [31:0] bk_addr;
    logic [31:0] bk_wdata;
    logic [31:0] bk_rdata = '0;
    logic rx_push;
    logic [7:0] rx_data;
    logic rx_full;
    logic tx_pop;
    logic [7:0] tx_data;
    logic tx_empty;

    mem_pkg::mem_req_t tbl_req [n_rows];
    logic [95:0] tbl_name [n_rows];
    logic [7:0] rx_bytes [n_rx];
    logic [31:0] bk_mem [mem_words];
    logic rd_q = 1'b0;
    int lat_cnt = 0;
    int n_added;
    int cur_row;
    int value_errs;
    int other_errs;
    logic all_seen;
    logic end_of_test;
    logic timed_out;

    initial clk = 1'b0;
    always #2 clk = ~clk;

    mem_subsys_top #(
        .cache_lines    (cache_lines),
        .refill_latency (refill_latency),
        .fifo_depth     (fifo_depth)
    ) u_dut (
        .clk (clk), .rstn (rstn),
        .req_valid (req_valid), .req_ready (req_ready), .req (req),
        .wb_valid (wb_valid), .wb (wb),
        .bk_rd_en (bk_rd_en), .bk_wr_en (bk_wr_en), .bk_addr (bk_addr),
        .bk_wdata (bk_wdata), .bk_rdata (bk_rdata),
        .rx_push (rx_push), .rx_data (rx_data), .rx_full (rx_full),
        .tx_pop (tx_pop), .tx_data (tx_data), .tx_empty (tx_empty)
    );

    mem_checker #(
        .n_rows     (n_rows),
        .n_rx       (n_rx),
        .mem_words  (mem_words),
        .fifo_depth (fifo_depth)
    ) u_checker (
        .clk (clk), .rstn (rstn), .wb_valid (wb_valid), .wb (wb),
        .bk_wr_en (bk_wr_en), .bk_addr (bk_addr), .bk_wdata (bk_wdata),
        .rx_push (rx_push), .rx_full (rx_full),
        .tx_pop (tx_pop), .tx_empty (tx_empty), .tx_data (tx_data),
        .tbl_req (tbl_req), .tbl_name (tbl_name), .rx_bytes (rx_bytes),
        .bk_image (bk_mem), .end_of_test (end_of_test),
        .value_errs (value_errs), .other_errs (other_errs), .all_seen (all_seen)
    );

    // galois lfsr with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic fill_backing_memory();
        logic [15:0] s;
        logic [31:0] w;
        s = 16'd18027;
        w = '0;
        for (int i = 0; i < mem_words; i++) begin
            for (int b = 0; b < 32; b++) begin
                s = lfsr_next(s);
                w = {w[30:0], s[0]};
            end
            bk_mem[i] = w;
        end
    endtask

    task automatic add_row(input logic [95:0] name, input mem_pkg::mem_op_e op,
                           input logic [4:0] rd, input logic [31:0] addr,
                           input logic [31:0] wdata);
        tbl_name[n_added] = name;
        tbl_req[n_added] = {op, rd, addr, wdata};
        n_added++;
    endtask

    task automatic apply_table();
        @(posedge clk);
        for (int i = 0; i < n_rows; i++) begin
            cur_row = i;
            req_valid <= 1'b1;
            req <= tbl_req[i];
            do @(posedge clk); while (!req_ready);
        end
        req_valid <= 1'b0;
        cur_row = n_rows;
        wait (all_seen);
    endtask

    // backing memory returns the word refill_latency cycles after bk_rd_en rises
    always @(posedge clk) begin
        rd_q <= bk_rd_en;
        if (bk_wr_en) begin
            bk_mem[(bk_addr >> 2) % mem_words] <= bk_wdata;
        end
        if (bk_rd_en && !rd_q) begin
            lat_cnt <= refill_latency - 1;
        end else if (lat_cnt != 0) begin
            lat_cnt <= lat_cnt - 1;
        end
        bk_rdata <= (lat_cnt == 1) ? bk_mem[(bk_addr >> 2) % mem_words] : 'x;
    end

    // receive bytes show up only after the serial load has stalled
    initial begin
        rx_push = 1'b0;
        rx_data = '0;
        wait (cur_row == rx_row + 1);
        repeat (5) @(posedge clk);
        // bytes past n_rx are never loaded and fill the fifo until a push is dropped
        for (int i = 0; i < n_rx + fifo_depth + 1; i++) begin
            rx_push <= 1'b1;
            rx_data <= (i < n_rx) ? rx_bytes[i] : 8'(i);
            @(posedge clk);
        end
        rx_push <= 1'b0;
    end

    // drain once a serial store is stuck behind a full fifo
    initial begin
        tx_pop = 1'b0;
        wait (cur_row == tx_row + fifo_depth + 1);
        repeat (6) @(posedge clk);
        forever begin
            tx_pop <= !tx_empty;
            @(posedge clk);
        end
    end

    initial begin
        rstn = 1'b0;
        req_valid = 1'b0;
        req = '0;
        end_of_test = 1'b0;
        timed_out = 1'b0;
        n_added = 0;
        cur_row = -1;
        rx_bytes[0] = 8'h5a;
        rx_bytes[1] = 8'hc3;
        fill_backing_memory();
        add_row("alu", mem_pkg::op_alu, 5'd1, 32'h12345678, 32'h0);
        add_row("nop", mem_pkg::op_nop, 5'd2, 32'h0, 32'h0);
        add_row("ld_miss", mem_pkg::op_load, 5'd3, 32'h10, 32'h0);
        add_row("ld_hit", mem_pkg::op_load, 5'd4, 32'h10, 32'h0);
        add_row("st_hit", mem_pkg::op_store, 5'd0, 32'h10, 32'hcafef00d);
        add_row("ld_after_st", mem_pkg::op_load, 5'd5, 32'h10, 32'h0);
        add_row("ld_evict", mem_pkg::op_load, 5'd6, 32'h50, 32'h0);
        add_row("ld_refetch", mem_pkg::op_load, 5'd7, 32'h10, 32'h0);
        add_row("st_uncached", mem_pkg::op_store, 5'd0, 32'h20, 32'hdeadbeef);
        add_row("ld_uncached", mem_pkg::op_load, 5'd8, 32'h20, 32'h0);
        add_row("rx_wait", mem_pkg::op_load, 5'd9, uart, 32'h0);
        add_row("rx_next", mem_pkg::op_load, 5'd10, uart, 32'h0);
        for (int i = 0; i < 6; i++) begin
            add_row("tx_store", mem_pkg::op_store, 5'd0, uart, 32'ha1 + i);
        end
        add_row("alu_last", mem_pkg::op_alu, 5'd11, 32'h0badf00d, 32'h0);
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        fork
            apply_table();
            begin
                repeat (n_rows * (refill_latency + 20)) @(posedge clk);
                timed_out = 1'b1;
            end
        join_any
        disable fork;
        @(posedge clk);
        end_of_test <= 1'b1;
        repeat (2) @(posedge clk);
        if (timed_out) begin
            $display("watchdog expired before all writebacks and transmit bytes arrived");
        end
        $display("errors: %0d wrong values, %0d other failures, %0d timeouts",
            value_errs, other_errs, timed_out);
        if (value_errs == 0 && other_errs == 0 && !timed_out) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- src/dcache_array.sv
module dcache_array #(
    parameter int cache_lines = mem_pkg::cache_lines
) (
    input  logic        clk,
    input  logic        rstn,
    input  logic        rd,
    input  logic        wr,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    input  logic        fill_en,
    input  logic [31:0] fill_data,
    output logic        hit,
    output logic [31:0] rdata
);

    localparam int idx_w = $clog2(cache_lines);
    localparam int tag_w = 30 - idx_w;

    logic [31:0] data_mem [cache_lines];
    logic [tag_w-1:0] tag_mem [cache_lines];
    logic [cache_lines-1:0] valid;

    logic [idx_w-1:0] idx;
    logic [tag_w-1:0] tag;

    // word address, byte offset dropped
    assign idx = addr[idx_w+1:2];
    assign tag = addr[31:idx_w+2];

    assign hit = (rd || wr) && valid[idx] && (tag_mem[idx] == tag);
    assign rdata = data_mem[idx];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid <= '0;
        end else if (fill_en) begin
            valid[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            // refill replaces whatever line held this index
            data_mem[idx] <= fill_data;
            tag_mem[idx] <= tag;
        end else if (wr && hit) begin
            data_mem[idx] <= wdata;
        end
    end

endmodule

//--- src/dcache_ctrl.sv
module dcache_ctrl (
    input  logic clk,
    input  logic rstn,
    input  logic miss_req,
    input  logic timer_done,
    output logic timer_start,
    output logic bk_rd_en,
    output logic fill_en,
    output logic refill_busy
);

    mem_pkg::refill_state_e state;
    mem_pkg::refill_state_e state_next;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= mem_pkg::st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            mem_pkg::st_idle: begin
                if (miss_req) begin
                    state_next = mem_pkg::st_wait;
                end
            end
            mem_pkg::st_wait: begin
                // backing memory word arrives with the next cycle
                if (timer_done) begin
                    state_next = mem_pkg::st_fill;
                end
            end
            mem_pkg::st_fill: begin
                state_next = mem_pkg::st_idle;
            end
            default: begin
                state_next = mem_pkg::st_idle;
            end
        endcase
    end

    // timer is loaded on the same edge that enters st_wait
    assign timer_start = (state == mem_pkg::st_idle) && miss_req;

    // read stays up until the line is written
    assign bk_rd_en = (state == mem_pkg::st_wait) || (state == mem_pkg::st_fill);
    assign fill_en = (state == mem_pkg::st_fill);
    assign refill_busy = (state != mem_pkg::st_idle);

endmodule

//--- src/mem_pkg.sv
package mem_pkg;

    // default sizes, overridden from the top level
    localparam int cache_lines = 16;
    localparam int refill_latency = 4;
    localparam int fifo_depth = 4;

    // word address of the serial data port, matched on bits 25:0
    localparam logic [25:0] uart_addr = 26'h3fffffc;

    // operation carried by each request
    typedef enum logic [1:0] {
        op_nop   = 2'd0,
        op_alu   = 2'd1,
        op_load  = 2'd2,
        op_store = 2'd3
    } mem_op_e;

    // refill controller states
    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_wait = 2'd1,
        st_fill = 2'd2
    } refill_state_e;

    // execute to memory request, 71 bits
    typedef struct packed {
        mem_op_e     op;
        // destination register
        logic [4:0]  rd;
        // effective address, or the ALU result for op_alu
        logic [31:0] addr;
        // store data, only the low byte matters for the serial port
        logic [31:0] wdata;
    } mem_req_t;

    // record handed to the register file, 38 bits
    typedef struct packed {
        logic [4:0]  rd;
        logic        regwrite;
        logic [31:0] data;
    } mem_wb_t;

endpackage

//--- src/mem_stage.sv
module mem_stage (
    input  logic             clk,
    input  logic             rstn,

    input  logic             req_valid,
    output logic             req_ready,
    input  mem_pkg::mem_req_t req,

    // data cache side
    output logic             cache_rd,
    output logic             cache_wr,
    output logic [31:0]      cache_addr,
    output logic [31:0]      cache_wdata,
    input  logic             hit,
    input  logic [31:0]      cache_rdata,
    output logic             miss_req,
    input  logic             refill_busy,
    output logic             bk_wr_en,

    // serial port fifos
    input  logic             rx_empty,
    input  logic [7:0]       rx_rdata,
    output logic             rx_pop,
    input  logic             tx_full,
    output logic             tx_push,
    output logic [7:0]       tx_wdata,

    output logic             wb_valid,
    output mem_pkg::mem_wb_t wb
);

    mem_pkg::mem_req_t req_q;
    logic occupied;
    logic is_uart;
    logic is_load;
    logic is_store;
    logic cache_load;
    logic done;

    // execute to memory register
    always_ff @(posedge clk) begin
        if (!rstn) begin
            occupied <= 1'b0;
        end else if (req_valid && req_ready) begin
            occupied <= 1'b1;
        end else if (done) begin
            occupied <= 1'b0;
        end
    end

    // payload only moves on a handshake
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            req_q <= req;
        end
    end

    assign is_uart = (req_q.addr[25:0] == mem_pkg::uart_addr);
    assign is_load = occupied && (req_q.op == mem_pkg::op_load);
    assign is_store = occupied && (req_q.op == mem_pkg::op_store);
    assign cache_load = is_load && !is_uart;

    // everything not aimed at the serial port goes to the cache
    assign cache_rd = cache_load;
    assign cache_wr = is_store && !is_uart;
    assign cache_addr = req_q.addr;
    assign cache_wdata = req_q.wdata;

    // write-through, the backing store always sees the store
    assign bk_wr_en = cache_wr;

    // one request per refill, controller ignores it while busy
    assign miss_req = cache_load && !hit && !refill_busy;

    assign rx_pop = is_load && is_uart && !rx_empty;
    assign tx_push = is_store && is_uart && !tx_full;
    assign tx_wdata = req_q.wdata[7:0];

    // can the held request finish this cycle
    always_comb begin
        done = 1'b0;
        if (occupied) begin
            case (req_q.op)
                mem_pkg::op_load:  done = is_uart ? !rx_empty : hit;
                mem_pkg::op_store: done = is_uart ? !tx_full : 1'b1;
                default:           done = 1'b1;
            endcase
        end
    end

    assign req_ready = !occupied || done;

    // writeback select
    always_comb begin
        wb.rd = req_q.rd;
        wb.regwrite = (req_q.op == mem_pkg::op_alu) || (req_q.op == mem_pkg::op_load);
        if (req_q.op == mem_pkg::op_load) begin
            wb.data = is_uart ? {24'b0, rx_rdata} : cache_rdata;
        end else begin
            wb.data = req_q.addr;
        end
    end

    assign wb_valid = done;

endmodule

//--- src/mem_subsys_top.sv
module mem_subsys_top #(
    parameter int cache_lines = mem_pkg::cache_lines,
    parameter int refill_latency = mem_pkg::refill_latency,
    parameter int fifo_depth = mem_pkg::fifo_depth
) (
    input  logic             clk,
    input  logic             rstn,

    input  logic             req_valid,
    output logic             req_ready,
    input  mem_pkg::mem_req_t req,

    output logic             wb_valid,
    output mem_pkg::mem_wb_t wb,

    // backing memory
    output logic             bk_rd_en,
    output logic             bk_wr_en,
    output logic [31:0]      bk_addr,
    output logic [31:0]      bk_wdata,
    input  logic [31:0]      bk_rdata,

    // serial port
    input  logic             rx_push,
    input  logic [7:0]       rx_data,
    output logic             rx_full,
    input  logic             tx_pop,
    output logic [7:0]       tx_data,
    output logic             tx_empty
);

    logic cache_rd;
    logic cache_wr;
    logic [31:0] cache_addr;
    logic [31:0] cache_wdata;
    logic hit;
    logic [31:0] cache_rdata;
    logic miss_req;
    logic refill_busy;
    logic fill_en;
    logic timer_start;
    logic timer_done;
    logic rx_empty;
    logic [7:0] rx_rdata;
    logic rx_pop;
    logic tx_full;
    logic tx_push;
    logic [7:0] tx_wdata;

    // both reads and write-through stores use the stage address
    assign bk_addr = cache_addr;
    assign bk_wdata = cache_wdata;

    mem_stage u_stage (
        .clk         (clk),
        .rstn        (rstn),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req         (req),
        .cache_rd    (cache_rd),
        .cache_wr    (cache_wr),
        .cache_addr  (cache_addr),
        .cache_wdata (cache_wdata),
        .hit         (hit),
        .cache_rdata (cache_rdata),
        .miss_req    (miss_req),
        .refill_busy (refill_busy),
        .bk_wr_en    (bk_wr_en),
        .rx_empty    (rx_empty),
        .rx_rdata    (rx_rdata),
        .rx_pop      (rx_pop),
        .tx_full     (tx_full),
        .tx_push     (tx_push),
        .tx_wdata    (tx_wdata),
        .wb_valid    (wb_valid),
        .wb          (wb)
    );

    dcache_ctrl u_ctrl (
        .clk         (clk),
        .rstn        (rstn),
        .miss_req    (miss_req),
        .timer_done  (timer_done),
        .timer_start (timer_start),
        .bk_rd_en    (bk_rd_en),
        .fill_en     (fill_en),
        .refill_busy (refill_busy)
    );

    refill_timer #(
        .refill_latency (refill_latency)
    ) u_timer (
        .clk   (clk),
        .rstn  (rstn),
        .start (timer_start),
        .done  (timer_done)
    );

    dcache_array #(
        .cache_lines (cache_lines)
    ) u_cache (
        .clk       (clk),
        .rstn      (rstn),
        .rd        (cache_rd),
        .wr        (cache_wr),
        .addr      (cache_addr),
        .wdata     (cache_wdata),
        .fill_en   (fill_en),
        .fill_data (bk_rdata),
        .hit       (hit),
        .rdata     (cache_rdata)
    );

    // receive side, filled from outside
    mmio_fifo #(
        .fifo_depth (fifo_depth)
    ) u_rx (
        .clk   (clk),
        .rstn  (rstn),
        .push  (rx_push),
        .wdata (rx_data),
        .pop   (rx_pop),
        .rdata (rx_rdata),
        .empty (rx_empty),
        .full  (rx_full)
    );

    // transmit side, drained from outside
    mmio_fifo #(
        .fifo_depth (fifo_depth)
    ) u_tx (
        .clk   (clk),
        .rstn  (rstn),
        .push  (tx_push),
        .wdata (tx_wdata),
        .pop   (tx_pop),
        .rdata (tx_data),
        .empty (tx_empty),
        .full  (tx_full)
    );

endmodule

//--- src/mmio_fifo.sv
module mmio_fifo #(
    parameter int fifo_depth = mem_pkg::fifo_depth
) (
    input  logic       clk,
    input  logic       rstn,
    input  logic       push,
    input  logic [7:0] wdata,
    input  logic       pop,
    output logic [7:0] rdata,
    output logic       empty,
    output logic       full
);

    localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cnt_w = $clog2(fifo_depth + 1);

    logic [7:0] mem [fifo_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic do_push;
    logic do_pop;

    assign empty = (count == '0);
    assign full = (count == cnt_w'(fifo_depth));

    // overflow and underflow are dropped
    assign do_push = push && !full;
    assign do_pop = pop && !empty;

    // head of the queue is always visible
    assign rdata = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

endmodule

//--- src/refill_timer.sv
module refill_timer #(
    parameter int refill_latency = mem_pkg::refill_latency
) (
    input  logic clk,
    input  logic rstn,
    input  logic start,
    output logic done
);

    localparam int cnt_w = $clog2(refill_latency + 1);

    logic [cnt_w-1:0] count;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            count <= '0;
        end else if (start) begin
            count <= cnt_w'(refill_latency);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // last cycle of the wait
    assign done = (count == cnt_w'(1));

endmodule

//--- vlog.f
src/mem_pkg.sv
src/refill_timer.sv
src/dcache_ctrl.sv
src/dcache_array.sv
src/mmio_fifo.sv
src/mem_stage.sv
src/mem_subsys_top.sv
sim/mem_checker.sv
sim/tb_mem_subsys.sv
